//--- verilog/uart_defines.svh
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// ----------------------------------------
// Register map in word offsets from address bits 3:2.
// ----------------------------------------
`define UART_REG_CLK_DIV 2'b00
`define UART_REG_STATUS  2'b01
`define UART_REG_DATA    2'b10

// ----------------------------------------
// Line format.
// ----------------------------------------
`define UART_DIV_W      16
`define UART_DATA_W     8
`define UART_FRAME_BITS 10  // Start, eight data bits, stop.

`endif

//--- verilog/uart_pkg.sv
`include "uart_defines.svh"

package uart_pkg;

    // One cycle request from the peripheral bus.
    typedef struct packed {
        logic        sel;
        logic        read;
        logic [3:0]  write_mask;
        logic [31:0] address;
        logic [31:0] write_value;
    } uart_bus_req_t;

    // Received character with its one cycle strobe.
    typedef struct packed {
        logic                    valid;
        logic [`UART_DATA_W-1:0] data;
    } uart_rx_byte_t;

    // The write word seen either as divisor bytes or as a transmit character.
    typedef union packed {
        struct packed {
            logic [15:0]                 spare;
            logic [`UART_DIV_W/2-1:0]    div_hi;
            logic [`UART_DIV_W/2-1:0]    div_lo;
        } div;
        struct packed {
            logic [31-`UART_DATA_W:0]    spare;
            logic [`UART_DATA_W-1:0]     data;
        } tx;
    } uart_wdata_u;

endpackage

//--- verilog/uart_tx.sv
`timescale 1ns/1ps

`include "uart_defines.svh"

module uart_tx
    import uart_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`UART_DIV_W-1:0]  clk_div,
    input  logic                    tx_start,
    input  logic [`UART_DATA_W-1:0] tx_data,
    output logic                    tx_busy,
    output logic                    tx
);

    localparam int CNT_W = $clog2(`UART_FRAME_BITS + 1);

    logic [`UART_DIV_W-1:0]      bit_clks;  // Cycles left in the current bit.
    logic [CNT_W-1:0]            bits_left;
    logic [`UART_FRAME_BITS-1:0] frame;
    logic                        bit_done;

    assign bit_done = tx_busy && (bit_clks == '0);
    assign tx_busy  = (bits_left != '0);

    // The line always shows the low end of the frame.
    assign tx = frame[0];

    // ----------------------------------------
    // Bit timer and frame shifter.
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            bits_left <= '0;
            frame     <= '1;  // Line idles high.
        end else if (tx_start) begin
            bits_left <= CNT_W'(`UART_FRAME_BITS);
            frame     <= {1'b1, tx_data, 1'b0};
        end else if (bit_done) begin
            bits_left <= bits_left - 1'b1;
            frame     <= {1'b1, frame[`UART_FRAME_BITS-1:1]};
        end
    end

    // Each bit holds for clk_div+1 cycles.
    always_ff @(posedge clk) begin
        if (tx_start || bit_done) begin
            bit_clks <= clk_div;
        end else if (tx_busy) begin
            bit_clks <= bit_clks - 1'b1;
        end
    end

endmodule

//--- verilog/uart_rx.sv
`timescale 1ns/1ps

`include "uart_defines.svh"

module uart_rx
    import uart_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`UART_DIV_W-1:0] clk_div,
    input  logic                   rx,
    output uart_rx_byte_t          rx_byte
);

    localparam logic [1:0] RX_IDLE  = 2'd0;
    localparam logic [1:0] RX_START = 2'd1;
    localparam logic [1:0] RX_DATA  = 2'd2;
    localparam logic [1:0] RX_STOP  = 2'd3;

    logic [1:0]              state;
    logic [`UART_DIV_W-1:0]  bit_clks;
    logic [2:0]              bit_idx;
    logic [`UART_DATA_W-1:0] shift;
    logic [`UART_DATA_W-1:0] byte_data;
    logic                    byte_valid;
    logic                    sample;

    // A sample is taken when the bit timer runs out.
    assign sample = (state != RX_IDLE) && (bit_clks == '0);

    assign rx_byte.valid = byte_valid;
    assign rx_byte.data  = byte_data;

    // ----------------------------------------
    // Frame FSM.
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= RX_IDLE;
            bit_idx    <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (!rx) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (sample) begin
                        // A start bit that went high again was a glitch.
                        state   <= rx ? RX_IDLE : RX_DATA;
                        bit_idx <= '0;
                    end
                end
                RX_DATA: begin
                    if (sample) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                default: begin
                    if (sample) begin
                        state      <= RX_IDLE;
                        byte_valid <= rx;  // Framing error drops the byte.
                    end
                end
            endcase
        end
    end

    // Half a bit from the falling edge, then whole bits.
    always_ff @(posedge clk) begin
        if (state == RX_IDLE) begin
            bit_clks <= clk_div >> 1;
        end else if (sample) begin
            bit_clks <= clk_div;
        end else begin
            bit_clks <= bit_clks - 1'b1;
        end
    end

    // ----------------------------------------
    // Data path with the least significant bit first.
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (sample && state == RX_DATA) begin
            shift <= {rx, shift[`UART_DATA_W-1:1]};
        end
        if (sample && state == RX_STOP) begin
            byte_data <= shift;
        end
    end

endmodule

//--- verilog/uart_regs.sv
`timescale 1ns/1ps

`include "uart_defines.svh"

module uart_regs
    import uart_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  uart_bus_req_t           bus,
    input  logic                    tx_busy,
    input  uart_rx_byte_t           rx_byte,
    output logic [31:0]             read_value,
    output logic [`UART_DIV_W-1:0]  clk_div,
    output logic                    tx_start,
    output logic [`UART_DATA_W-1:0] tx_data
);

    uart_wdata_u             wdata;
    logic [1:0]              offset;
    logic                    div_sel;
    logic                    data_sel;
    logic                    tx_ready;
    logic                    tx_fire;
    logic                    rx_clear;
    logic                    rx_ready;
    logic [`UART_DATA_W-1:0] rx_data;

    assign wdata  = bus.write_value;
    assign offset = bus.address[3:2];

    assign div_sel  = bus.sel && (offset == `UART_REG_CLK_DIV);
    assign data_sel = bus.sel && (offset == `UART_REG_DATA);

    // A start still in flight counts as busy.
    assign tx_ready = !(tx_busy || tx_start);
    assign tx_fire  = data_sel && bus.write_mask[0] && tx_ready;
    assign rx_clear = data_sel && bus.read;

    // ----------------------------------------
    // Read mux.
    // ----------------------------------------
    always_comb begin
        read_value = '0;
        if (bus.sel) begin
            case (offset)
                `UART_REG_CLK_DIV: begin
                    read_value = {{(32-`UART_DIV_W){1'b0}}, clk_div};
                end
                `UART_REG_STATUS: begin
                    read_value = {30'b0, rx_ready, tx_ready};
                end
                `UART_REG_DATA: begin
                    // Upper bits read as ones while nothing waits.
                    read_value = {{(32-`UART_DATA_W){~rx_ready}},
                                  rx_ready ? rx_data : {`UART_DATA_W{1'b0}}};
                end
                default: begin
                    read_value = '0;
                end
            endcase
        end
    end

    // ----------------------------------------
    // Divisor written per byte lane.
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (div_sel && bus.write_mask[1]) begin
            clk_div[`UART_DIV_W-1:`UART_DIV_W/2] <= wdata.div.div_hi;
        end
        if (div_sel && bus.write_mask[0]) begin
            clk_div[`UART_DIV_W/2-1:0] <= wdata.div.div_lo;
        end
    end

    // Control flags.
    always_ff @(posedge clk) begin
        if (reset) begin
            tx_start <= 1'b0;
            rx_ready <= 1'b0;
        end else begin
            tx_start <= tx_fire;
            if (rx_byte.valid) begin
                rx_ready <= 1'b1;  // A new byte beats a clearing read.
            end else if (rx_clear) begin
                rx_ready <= 1'b0;
            end
        end
    end

    // Character buffers.
    always_ff @(posedge clk) begin
        if (tx_fire) begin
            tx_data <= wdata.tx.data;
        end
        if (rx_byte.valid) begin
            rx_data <= rx_byte.data;  // Overwrites an unread byte.
        end
    end

endmodule

//--- verilog/uart.sv
`timescale 1ns/1ps

`include "uart_defines.svh"

module uart
    import uart_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          rx,
    output logic          tx,
    input  uart_bus_req_t bus,
    output logic [31:0]   read_value
);

    logic [`UART_DIV_W-1:0]  clk_div;
    logic                    tx_start;
    logic [`UART_DATA_W-1:0] tx_data;
    logic                    tx_busy;
    uart_rx_byte_t           rx_byte;

    // ----------------------------------------
    // Register block.
    // ----------------------------------------
    uart_regs u_regs (
        .clk        (clk),
        .reset      (reset),
        .bus        (bus),
        .tx_busy    (tx_busy),
        .rx_byte    (rx_byte),
        .read_value (read_value),
        .clk_div    (clk_div),
        .tx_start   (tx_start),
        .tx_data    (tx_data)
    );

    // ----------------------------------------
    // Serial engines.
    // ----------------------------------------
    uart_tx u_tx (
        .clk      (clk),
        .reset    (reset),
        .clk_div  (clk_div),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx_busy  (tx_busy),
        .tx       (tx)
    );

    uart_rx u_rx (
        .clk     (clk),
        .reset   (reset),
        .clk_div (clk_div),
        .rx      (rx),
        .rx_byte (rx_byte)
    );

endmodule

//--- tb/uart_tb.sv
`timescale 1ns/1ps

`include "uart_defines.svh"

module uart_tb
    import uart_pkg::*;
();

    localparam int CLK_HALF   = 5;
    localparam int CLK_PERIOD = 2 * CLK_HALF;
    localparam int RX_TIMEOUT = 200;  // Status polls allowed for one received byte.
    localparam int LOOP_BYTES = 4;

    logic          clk;
    logic          reset;
    uart_bus_req_t bus;
    logic [31:0]   read_value;
    logic          tx;
    logic          rx_line;
    logic          rx_drive;
    logic          use_loop;

    logic [31:0]            rng_state;
    logic [`UART_DIV_W-1:0] div_model;
    int                     bit_cycles;
    logic                   check_read;
    logic [31:0]            exp_read;
    logic                   line_quiet;
    logic [9:0]             exp_frame;

    // Line monitor state.
    logic       mon_active;
    int         mon_cnt;
    logic [3:0] mon_idx;
    int         mon_frames;
    logic       mon_sample;
    logic       mon_exp_bit;

    always #CLK_HALF clk = ~clk;

    // The receive pin sees either the looped back tx or the testbench's own drive.
    assign rx_line = use_loop ? tx : rx_drive;

    uart dut_i (
        .clk        (clk),
        .reset      (reset),
        .rx         (rx_line),
        .tx         (tx),
        .bus        (bus),
        .read_value (read_value)
    );

    // ----------------------------------------
    // Helpers.
    // ----------------------------------------
    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Byte lane 0 is the divisor low byte, lane 1 the high byte.
    function automatic logic [`UART_DIV_W-1:0] merge_div(input logic [`UART_DIV_W-1:0] old,
                                                         input logic [3:0] mask,
                                                         input logic [31:0] value);
        logic [`UART_DIV_W-1:0] merged;
        merged = old;
        if (mask[0]) merged[7:0] = value[7:0];
        if (mask[1]) merged[15:8] = value[15:8];
        return merged;
    endfunction

    function automatic logic [9:0] make_frame(input logic [7:0] data);
        return {1'b1, data, 1'b0};  // Bit 0 goes on the line first.
    endfunction

    task automatic bus_write(input logic [1:0] offset, input logic [3:0] mask,
                             input logic [31:0] value);
        bus.sel         = 1'b1;
        bus.read        = 1'b0;
        bus.write_mask  = mask;
        bus.address     = {28'h0, offset, 2'b00};
        bus.write_value = value;
        @(posedge clk);
        #1;
        bus = '0;
    endtask

    // The read is checked at the closing edge, and captured just before it.
    task automatic bus_read(input logic sel, input logic [1:0] offset, input logic check,
                            input logic [31:0] expected, output logic [31:0] value);
        bus.sel         = sel;
        bus.read        = 1'b1;
        bus.write_mask  = 4'b0000;
        bus.address     = {28'h0, offset, 2'b00};
        bus.write_value = 32'h0;
        exp_read        = expected;
        check_read      = check;
        #(CLK_PERIOD - 2);
        value = read_value;
        @(posedge clk);
        #1;
        bus        = '0;
        check_read = 1'b0;
    endtask

    task automatic read_expect(input logic [1:0] offset, input logic [31:0] expected);
        logic [31:0] value;
        bus_read(1'b1, offset, 1'b1, expected, value);
    endtask

    task automatic wait_rx_ready;
        logic [31:0] status;
        int          polls;
        status = 32'h0;
        polls  = 0;
        while (!status[1] && polls < RX_TIMEOUT) begin
            bus_read(1'b1, `UART_REG_STATUS, 1'b0, 32'h0, status);
            polls++;
        end
        if (!status[1]) begin
            report_failure($sformatf("receive ready did not rise within %0d polls", RX_TIMEOUT));
        end
    endtask

    task automatic drive_rx_frame(input logic [7:0] data, input logic stop_bit);
        logic [9:0] bits;
        bits = {stop_bit, data, 1'b0};
        for (int i = 0; i < `UART_FRAME_BITS; i++) begin
            rx_drive = bits[0];
            bits     = bits >> 1;
            repeat (bit_cycles) @(posedge clk);
            #1;
        end
        rx_drive = 1'b1;
    endtask

    // ----------------------------------------
    // Line monitor that samples tx in bit centers.
    // ----------------------------------------
    assign mon_sample  = mon_active && (mon_cnt == 0);
    assign mon_exp_bit = exp_frame[mon_idx];

    always @(posedge clk) begin
        if (reset) begin
            mon_active <= 1'b0;
            mon_cnt    <= 0;
            mon_idx    <= 4'd0;
            mon_frames <= 0;
        end else if (!mon_active) begin
            if (!tx) begin
                mon_active <= 1'b1;
                mon_cnt    <= bit_cycles / 2 - 1;  // First sample half a bit in.
                mon_idx    <= 4'd0;
            end
        end else if (mon_cnt == 0) begin
            mon_cnt <= bit_cycles - 1;
            if (mon_idx == 4'(`UART_FRAME_BITS - 1)) begin
                mon_active <= 1'b0;
                mon_frames <= mon_frames + 1;
            end else begin
                mon_idx <= mon_idx + 1'b1;
            end
        end else begin
            mon_cnt <= mon_cnt - 1;
        end
    end

    read_check: assert property (@(posedge clk) disable iff (reset)
        check_read |-> read_value == exp_read)
        else report_failure($sformatf("** Error: read_value = %h, expected %h",
                                      $sampled(read_value), $sampled(exp_read)));

    tx_bit_check: assert property (@(posedge clk) disable iff (reset)
        mon_sample |-> tx == mon_exp_bit)
        else report_failure($sformatf("** Error: tx = %h, expected %h in frame bit %0d",
                                      $sampled(tx), $sampled(mon_exp_bit), $sampled(mon_idx)));

    tx_idle_check: assert property (@(posedge clk) disable iff (reset)
        line_quiet |-> tx)
        else report_failure($sformatf("** Error: tx = %h, expected 1 on an idle line",
                                      $sampled(tx)));

    // ----------------------------------------
    // Stimulus.
    // ----------------------------------------
    initial begin
        logic [7:0]  tx_byte;
        logic [31:0] ignored;
        int          frames_before;
        int          frame_cycles;

        clk        = 1'b0;
        reset      = 1'b1;
        bus        = '0;
        rx_drive   = 1'b1;
        use_loop   = 1'b0;
        rng_state  = 32'h89ce_5878;
        div_model  = '0;
        bit_cycles = 4;
        check_read = 1'b0;
        exp_read   = 32'h0;
        line_quiet = 1'b1;
        exp_frame  = 10'h3ff;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        // Reset state.
        read_expect(`UART_REG_STATUS, 32'h0000_0001);
        read_expect(`UART_REG_DATA, 32'hffff_ff00);

        // Divisor lanes merge and the upper half is not a register.
        bus_write(`UART_REG_CLK_DIV, 4'b0011, 32'h0000_1234);
        div_model = merge_div(div_model, 4'b0011, 32'h0000_1234);
        read_expect(`UART_REG_CLK_DIV, {16'h0, div_model});
        bus_write(`UART_REG_CLK_DIV, 4'b0001, 32'hffff_ff5c);
        div_model = merge_div(div_model, 4'b0001, 32'hffff_ff5c);
        read_expect(`UART_REG_CLK_DIV, {16'h0, div_model});
        bus_write(`UART_REG_CLK_DIV, 4'b0010, 32'h0000_a700);
        div_model = merge_div(div_model, 4'b0010, 32'h0000_a700);
        read_expect(`UART_REG_CLK_DIV, {16'h0, div_model});
        bus_write(`UART_REG_CLK_DIV, 4'b1100, 32'hbeef_0000);
        div_model = merge_div(div_model, 4'b1100, 32'hbeef_0000);
        read_expect(`UART_REG_CLK_DIV, {16'h0, div_model});
        bus_read(1'b0, `UART_REG_CLK_DIV, 1'b1, 32'h0, ignored);

        bus_write(`UART_REG_CLK_DIV, 4'b0011, 32'h0000_0003);
        div_model  = merge_div(div_model, 4'b0011, 32'h0000_0003);
        bit_cycles = int'(div_model) + 1;

        // One frame on tx, with a second write landing while busy.
        rng_state     = lcg_next(rng_state);
        tx_byte       = rng_state[23:16];
        exp_frame     = make_frame(tx_byte);
        frames_before = mon_frames;
        frame_cycles  = `UART_FRAME_BITS * bit_cycles;
        line_quiet    = 1'b0;
        bus_write(`UART_REG_DATA, 4'b0001, {24'ha5a5a5, tx_byte});
        for (int j = 0; j <= frame_cycles + 4; j++) begin
            if (j == 5) begin
                bus_write(`UART_REG_DATA, 4'b0001, {24'h0, ~tx_byte});
            end else begin
                read_expect(`UART_REG_STATUS, (j > frame_cycles) ? 32'h1 : 32'h0);
            end
        end
        line_quiet = 1'b1;
        repeat (20) @(posedge clk);
        #1;
        frame_count: assert (mon_frames == frames_before + 1)
            else report_failure($sformatf("line monitor saw %0d frames instead of one",
                                          mon_frames - frames_before));
        line_quiet = 1'b0;

        // Loopback of random bytes.
        use_loop = 1'b1;
        for (int k = 0; k < LOOP_BYTES; k++) begin
            rng_state = lcg_next(rng_state);
            tx_byte   = rng_state[23:16];
            exp_frame = make_frame(tx_byte);
            bus_write(`UART_REG_DATA, 4'b0001, {24'h0, tx_byte});
            wait_rx_ready();
            read_expect(`UART_REG_DATA, {24'h0, tx_byte});
            read_expect(`UART_REG_STATUS, 32'h0000_0001);
        end

        // Glitch and framing error on a directly driven line.
        use_loop = 1'b0;
        rx_drive = 1'b0;
        @(posedge clk);
        #1;
        rx_drive = 1'b1;
        // Long enough for a wrongly accepted frame to finish.
        repeat ((`UART_FRAME_BITS + 1) * bit_cycles) @(posedge clk);
        #1;
        read_expect(`UART_REG_STATUS, 32'h0000_0001);

        rng_state = lcg_next(rng_state);
        tx_byte   = rng_state[23:16];
        drive_rx_frame(tx_byte, 1'b0);
        repeat (3 * bit_cycles) @(posedge clk);
        #1;
        read_expect(`UART_REG_STATUS, 32'h0000_0001);

        // The same driver with a good stop bit does deliver.
        drive_rx_frame(tx_byte, 1'b1);
        wait_rx_ready();
        read_expect(`UART_REG_DATA, {24'h0, tx_byte});

        repeat (5) @(posedge clk);
        $display("TEST PASS");
        $finish;
    end

endmodule

//--- uart_sys.f
+incdir+verilog
verilog/uart_pkg.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_regs.sv
verilog/uart.sv
tb/uart_tb.sv

//--- Makefile
# Verilator build and run of the UART testbench.
.PHONY: all compile run clean

all: run

compile: obj_dir/uart_tb

obj_dir/uart_tb: uart_sys.f verilog/uart_defines.svh verilog/uart_pkg.sv verilog/uart_tx.sv \
		verilog/uart_rx.sv verilog/uart_regs.sv verilog/uart.sv tb/uart_tb.sv
	verilator --binary --timing --assert --top-module uart_tb \
		-f uart_sys.f -Mdir obj_dir -o uart_tb

# The testbench ends with $fatal on failure, so the exit status carries the result.
run: compile
	./obj_dir/uart_tb

clean:
	rm -rf obj_dir
